//--- all.f
+incdir+dv
hw/aib_tx_pkg.sv
hw/aib_rstn_sync.sv
hw/aib_tx_ctrl.sv
hw/aib_tx_fifo.sv
hw/aib_tx_dbi.sv
hw/aib_tx_chnl.sv
dv/tb_aib_tx_chnl.sv

//--- run.sh
#!/bin/sh
# Build and run the TX channel testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_aib_tx_chnl -f all.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test passed$" sim.log; then
  echo "Simulation PASSED"
else
  echo "Simulation FAILED"
  exit 1
fi

//--- dv/aib_tx_tasks.svh
// TX channel directed tests
// Check, drive and wait helpers

task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                           input logic [WORD_W-1:0] exp);
  if (got !== exp) begin
    stop_on_error($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
  end
endtask

// New settings are applied under reset
task automatic setup_and_reset(input logic [1:0] mode, input logic [3:0] delay,
                               input bit dbi, input bit swap, input bit wm,
                               input bit gen2, input logic [4:0] mkbit);
  @(negedge m_ns_fwd_clk);
  mon_en               = 1'b0;
  wr_en                = 1'b0;
  arst_n               = 1'b0;
  r_tx_fifo_mode       = mode;
  r_tx_phcomp_rd_delay = delay;
  r_tx_dbi_en          = dbi;
  r_txswap_en          = swap;
  r_tx_wm_en           = wm;
  m_gen2_mode          = gen2;
  r_tx_mkbit           = mkbit;
  exp_q.delete();
  model_fill = 0;
  repeat (RESET_CYCLES) @(negedge m_ns_fwd_clk);
  check_value("dout", dout, '0);
  check_value("dout_vld", WORD_W'(dout_vld), '0);
  check_value("tx_fifo_ovf", WORD_W'(tx_fifo_ovf), '0);
  arst_n = 1'b1;
  repeat (3) @(negedge m_ns_fwd_clk);   // Two-flop reset release
  mon_en = 1'b1;
endtask

// Holds the write strobe for one clock
task automatic write_group(input logic [IN_W-1:0] d, input bit accept);
  int n;
  n = (r_tx_fifo_mode == MODE_QUARTER) ? 4 : (r_tx_fifo_mode == MODE_HALF) ? 2 : 1;
  data_in_f = d;
  wr_en     = 1'b1;
  for (int i = 0; i < n; i++) begin
    if (accept) begin
      exp_q.push_back(model_word(d[i*WORD_W +: WORD_W], i == 0));
    end
  end
  @(negedge m_ns_fwd_clk);
  wr_en = 1'b0;
endtask

task automatic stream_groups(input int groups, input int gap);
  for (int g = 0; g < groups; g++) begin
    write_group(rand_bus(), 1'b1);
    repeat (gap) @(negedge m_ns_fwd_clk);
  end
endtask

// Extra idle cycles let the monitor catch stray outputs
task automatic wait_drain();
  int cycles;
  cycles = 0;
  while (exp_q.size() != 0) begin
    if (cycles == DRAIN_TIMEOUT) begin
      stop_on_error("Timeout while waiting for expected words to leave the DUT");
    end
    @(negedge m_ns_fwd_clk);
    cycles++;
  end
  repeat (4) @(negedge m_ns_fwd_clk);
endtask

function automatic logic [38:0] spread_ones(input int n, input int off);
  logic [38:0] r;
  r = '0;
  for (int b = 0; b < n; b++) begin
    r[(b*7 + off) % 39] = 1'b1;   // Step 7 reaches all 39 positions
  end
  return r;
endfunction

task automatic full_rate_stream();
  setup_and_reset(MODE_FULL, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
  stream_groups(40, 0);
  wait_drain();
  check_value("tx_fifo_ovf", WORD_W'(tx_fifo_ovf), '0);
endtask

task automatic half_rate_swap_marker();
  setup_and_reset(MODE_HALF, 4'd5, 1'b0, 1'b1, 1'b1, 1'b0, 5'd31);
  stream_groups(12, 1);
  wait_drain();
endtask

// Swap requested with gen2 on keeps lanes in place at quarter and half rate
task automatic gen2_no_swap();
  setup_and_reset(MODE_QUARTER, 4'd2, 1'b0, 1'b1, 1'b1, 1'b1, 5'd3);
  stream_groups(8, 3);
  wait_drain();
  setup_and_reset(MODE_HALF, 4'd2, 1'b0, 1'b1, 1'b1, 1'b1, 5'd10);
  stream_groups(8, 1);
  wait_drain();
endtask

// Counts around the 19/20 threshold, the extremes, then random words
task automatic dbi_threshold();
  int              hi_ones [8] = '{19, 20, 0, 39, 20, 19, 30, 1};
  int              lo_ones [8] = '{20, 19, 39, 0, 20, 19, 5, 38};
  logic [IN_W-1:0] d;
  setup_and_reset(MODE_FULL, 4'd1, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0);
  for (int i = 0; i < 16; i++) begin
    d = rand_bus();
    if (i < 8) begin
      d[78:40] = spread_ones(hi_ones[i], i);
      d[38:0]  = spread_ones(lo_ones[i], 3 * i);
    end
    write_group(d, 1'b1);
  end
  wait_drain();
endtask

task automatic reg_mode_bypass();
  logic [IN_W-1:0]   d;
  logic [WORD_W-1:0] exp;
  setup_and_reset(MODE_FULL, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
  mon_en         = 1'b0;   // dout_vld stays high in register mode
  r_tx_fifo_mode = MODE_REG;
  for (int i = 0; i < 16; i++) begin
    d           = rand_bus();
    data_in     = d[WORD_W-1:0];
    r_tx_dbi_en = i[0];
    exp         = model_word(d[WORD_W-1:0], 1'b0);
    @(negedge m_ns_fwd_clk);
    check_value("dout", dout, exp);
    check_value("dout_vld", WORD_W'(dout_vld), WORD_W'(1));
  end
  r_tx_fifo_mode = MODE_FULL;
  r_tx_dbi_en    = 1'b0;
endtask

// Back-to-back quarter groups fill the FIFO before reads start
task automatic overflow_drop();
  bit accept;
  setup_and_reset(MODE_QUARTER, 4'd15, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
  for (int g = 0; g < 6; g++) begin
    accept = (model_fill + 4 <= FIFO_DEPTH);   // No reads inside the start delay
    if (accept) begin
      model_fill += 4;
    end
    write_group(rand_bus(), accept);
  end
  check_value("tx_fifo_ovf", WORD_W'(tx_fifo_ovf), WORD_W'(1));
  wait_drain();
  stream_groups(3, 5);
  wait_drain();
  check_value("tx_fifo_ovf", WORD_W'(tx_fifo_ovf), WORD_W'(1));
  setup_and_reset(MODE_QUARTER, 4'd0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0);
  check_value("tx_fifo_ovf", WORD_W'(tx_fifo_ovf), '0);
endtask

//--- dv/tb_aib_tx_chnl.sv
// TX channel testbench
`timescale 1ns/1ps
`default_nettype none

module tb_aib_tx_chnl;

  import aib_tx_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 10;
  localparam int DRAIN_TIMEOUT = 300;

  logic              m_ns_fwd_clk;
  logic              arst_n;
  logic              atpg_mode;
  logic              m_gen2_mode;
  logic [IN_W-1:0]   data_in_f;
  logic [WORD_W-1:0] data_in;
  logic              wr_en;
  logic              r_tx_dbi_en;
  logic [1:0]        r_tx_fifo_mode;
  logic [3:0]        r_tx_phcomp_rd_delay;
  logic              r_txswap_en;
  logic              r_tx_wm_en;
  logic [4:0]        r_tx_mkbit;
  logic [WORD_W-1:0] dout;
  logic              dout_vld;
  logic              tx_fifo_ovf;

  integer            seed;
  logic [WORD_W-1:0] exp_q [$];   // Reference words in output order
  int                model_fill;  // Words the model believes are stored
  bit                mon_en;

  aib_tx_chnl uut (.*);

  initial begin
    m_ns_fwd_clk = 1'b0;
    forever #(CLK_PERIOD/2) m_ns_fwd_clk = ~m_ns_fwd_clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "Run stopped at first error");
  endtask

  // Flag set and data inverted when more than 19 of 39 bits are high
  function automatic logic [HALF_W-1:0] encode_half(input logic [HALF_W-1:0] h);
    if ($countones(h[38:0]) > 19) begin
      return {1'b1, ~h[38:0]};
    end
    return {1'b0, h[38:0]};
  endfunction

  // Expected output word for one word written now
  function automatic logic [WORD_W-1:0] model_word(input logic [WORD_W-1:0] w, input bit first);
    logic [WORD_W-1:0] r;
    int                mk;
    r  = w;
    mk = MK_BASE + int'(r_tx_mkbit);
    if (first && r_tx_fifo_mode == MODE_HALF && r_txswap_en && !m_gen2_mode) begin
      r = {w[79], w[38:0], w[39], w[78:40]};   // Gen1 lane swap
    end
    if (r_tx_wm_en && (r_tx_fifo_mode == MODE_HALF || r_tx_fifo_mode == MODE_QUARTER)) begin
      r[mk] = first;
    end
    if (r_tx_dbi_en) begin
      r = {encode_half(r[79:40]), encode_half(r[39:0])};
    end
    return r;
  endfunction

  function automatic logic [IN_W-1:0] rand_bus();
    logic [IN_W-1:0] r;
    for (int i = 0; i < IN_W/32; i++) begin
      r[i*32 +: 32] = $random(seed);
    end
    return r;
  endfunction

  // Pops one reference word per valid cycle
  always @(negedge m_ns_fwd_clk) begin
    if (mon_en && dout_vld) begin
      if (exp_q.size() == 0) begin
        stop_on_error("Output valid while no word was expected");
      end else begin
        check_value("dout", dout, exp_q.pop_front());
      end
    end
  end

  `include "aib_tx_tasks.svh"

  initial begin
    seed                 = 50;
    arst_n               = 1'b0;
    atpg_mode            = 1'b0;
    m_gen2_mode          = 1'b0;
    data_in_f            = '0;
    data_in              = '0;
    wr_en                = 1'b0;
    r_tx_dbi_en          = 1'b0;
    r_tx_fifo_mode       = MODE_FULL;
    r_tx_phcomp_rd_delay = 4'd0;
    r_txswap_en          = 1'b0;
    r_tx_wm_en           = 1'b0;
    r_tx_mkbit           = 5'd0;
    model_fill           = 0;
    mon_en               = 1'b0;
    full_rate_stream();
    half_rate_swap_marker();
    gen2_no_swap();
    dbi_threshold();
    reg_mode_bypass();
    overflow_drop();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/aib_tx_chnl.sv
// Die-to-die adapter TX channel top
`timescale 1ns/1ps
`default_nettype none

module aib_tx_chnl (
  input  logic                          m_ns_fwd_clk,
  input  logic                          arst_n,
  input  logic                          atpg_mode,
  input  logic                          m_gen2_mode,
  input  logic [aib_tx_pkg::IN_W-1:0]   data_in_f,    // FIFO modes
  input  logic [aib_tx_pkg::WORD_W-1:0] data_in,      // Register mode
  input  logic                          wr_en,
  input  logic                          r_tx_dbi_en,
  input  logic [1:0]                    r_tx_fifo_mode,
  input  logic [3:0]                    r_tx_phcomp_rd_delay,
  input  logic                          r_txswap_en,
  input  logic                          r_tx_wm_en,
  input  logic [4:0]                    r_tx_mkbit,
  output logic [aib_tx_pkg::WORD_W-1:0] dout,
  output logic                          dout_vld,
  output logic                          tx_fifo_ovf
);

  import aib_tx_pkg::*;

  logic              rd_rstn;
  logic [2:0]        grp_words;
  logic              reg_mode;
  logic              rd_en;
  logic              wr_ack;
  logic              fifo_empty;
  logic [WORD_W-1:0] fifo_dout;

  aib_rstn_sync u_rstn_sync (
    .m_ns_fwd_clk (m_ns_fwd_clk),
    .arst_n       (arst_n),
    .atpg_mode    (atpg_mode),
    .rd_rstn      (rd_rstn)
  );

  // fifo_vld only feeds the valid pipeline inside control
  aib_tx_ctrl u_ctrl (
    .m_ns_fwd_clk         (m_ns_fwd_clk),
    .rd_rstn              (rd_rstn),
    .r_tx_fifo_mode       (r_tx_fifo_mode),
    .r_tx_phcomp_rd_delay (r_tx_phcomp_rd_delay),
    .wr_ack               (wr_ack),
    .fifo_empty           (fifo_empty),
    .grp_words            (grp_words),
    .reg_mode             (reg_mode),
    .rd_en                (rd_en),
    .fifo_vld             (),
    .dout_vld             (dout_vld)
  );

  aib_tx_fifo u_fifo (
    .m_ns_fwd_clk   (m_ns_fwd_clk),
    .rd_rstn        (rd_rstn),
    .data_in_f      (data_in_f),
    .wr_en          (wr_en),
    .grp_words      (grp_words),
    .reg_mode       (reg_mode),
    .r_tx_fifo_mode (r_tx_fifo_mode),
    .m_gen2_mode    (m_gen2_mode),
    .r_txswap_en    (r_txswap_en),
    .r_tx_wm_en     (r_tx_wm_en),
    .r_tx_mkbit     (r_tx_mkbit),
    .rd_en          (rd_en),
    .fifo_dout      (fifo_dout),
    .fifo_empty     (fifo_empty),
    .wr_ack         (wr_ack),
    .tx_fifo_ovf    (tx_fifo_ovf)
  );

  aib_tx_dbi u_dbi (
    .m_ns_fwd_clk (m_ns_fwd_clk),
    .rd_rstn      (rd_rstn),
    .reg_mode     (reg_mode),
    .r_tx_dbi_en  (r_tx_dbi_en),
    .data_in      (data_in),
    .fifo_dout    (fifo_dout),
    .dout         (dout)
  );

endmodule

`default_nettype wire

//--- hw/aib_tx_dbi.sv
// TX data bus inversion
// Per-half DBI and register-mode bypass
`timescale 1ns/1ps
`default_nettype none

module aib_tx_dbi (
  input  logic                          m_ns_fwd_clk,
  input  logic                          rd_rstn,
  input  logic                          reg_mode,
  input  logic                          r_tx_dbi_en,
  input  logic [aib_tx_pkg::WORD_W-1:0] data_in,
  input  logic [aib_tx_pkg::WORD_W-1:0] fifo_dout,
  output logic [aib_tx_pkg::WORD_W-1:0] dout
);

  import aib_tx_pkg::*;

  tx_word_u sel_w;
  tx_word_u enc_w;

  // Invert a half when most of its data bits are high
  function automatic tx_half_t dbi_half(input tx_half_t h);
    int       ones;
    tx_half_t res;
    ones = 0;
    for (int i = 0; i < HALF_W-1; i++) begin
      ones += int'(h.data[i]);
    end
    if (ones > (HALF_W-1)/2) begin   // More than 19 of 39
      res.dbi  = 1'b1;
      res.data = ~h.data;
    end else begin
      res.dbi  = 1'b0;
      res.data = h.data;
    end
    return res;
  endfunction

  // Bypass word or FIFO word
  assign sel_w.flat = reg_mode ? data_in : fifo_dout;

  always_comb begin
    enc_w = sel_w;   // Pass unchanged with DBI off
    if (r_tx_dbi_en) begin
      enc_w.halves.hi = dbi_half(sel_w.halves.hi);
      enc_w.halves.lo = dbi_half(sel_w.halves.lo);
    end
  end

  always_ff @(posedge m_ns_fwd_clk or negedge rd_rstn) begin
    if (!rd_rstn) begin
      dout <= '0;
    end else begin
      dout <= enc_w.flat;
    end
  end

endmodule

`default_nettype wire

//--- hw/aib_tx_fifo.sv
// TX phase-compensation FIFO
// Group writes with lane swap and marker insertion
`timescale 1ns/1ps
`default_nettype none

module aib_tx_fifo (
  input  logic                          m_ns_fwd_clk,
  input  logic                          rd_rstn,
  input  logic [aib_tx_pkg::IN_W-1:0]   data_in_f,
  input  logic                          wr_en,
  input  logic [2:0]                    grp_words,
  input  logic                          reg_mode,
  input  logic [1:0]                    r_tx_fifo_mode,
  input  logic                          m_gen2_mode,
  input  logic                          r_txswap_en,
  input  logic                          r_tx_wm_en,
  input  logic [4:0]                    r_tx_mkbit,
  input  logic                          rd_en,
  output logic [aib_tx_pkg::WORD_W-1:0] fifo_dout,
  output logic                          fifo_empty,
  output logic                          wr_ack,
  output logic                          tx_fifo_ovf
);

  import aib_tx_pkg::*;

  logic [WORD_W-1:0]  mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;      // 0 to FIFO_DEPTH
  logic [FIFO_AW:0]   free_cnt;
  logic [FIFO_AW:0]   add_cnt;
  logic [FIFO_AW:0]   sub_cnt;
  logic               wr_req;
  logic               space_ok;
  logic               swap_on;
  logic               mark_on;
  tx_word_u           src_w;
  tx_word_u           first_w;
  logic [WORD_W-1:0]  grp_word [4];

  // Gen1 half-rate swaps the data lanes of the first word
  assign swap_on = (r_tx_fifo_mode == MODE_HALF) && r_txswap_en && !m_gen2_mode;
  assign mark_on = r_tx_wm_en &&
                   ((r_tx_fifo_mode == MODE_HALF) || (r_tx_fifo_mode == MODE_QUARTER));

  always_comb begin
    src_w.flat   = data_in_f[WORD_W-1:0];
    first_w      = src_w;
    if (swap_on) begin
      first_w.halves.hi.data = src_w.halves.lo.data;   // Flag bits stay put
      first_w.halves.lo.data = src_w.halves.hi.data;
    end

    grp_word[0] = first_w.flat;
    for (int i = 1; i < 4; i++) begin
      grp_word[i] = data_in_f[i*WORD_W +: WORD_W];
    end

    // Marker tags the first word, cleared on the rest
    if (mark_on) begin
      grp_word[0][MK_BASE + r_tx_mkbit] = 1'b1;
      for (int i = 1; i < 4; i++) begin
        grp_word[i][MK_BASE + r_tx_mkbit] = 1'b0;
      end
    end
  end

  // Whole group or nothing
  assign free_cnt = (FIFO_AW+1)'(FIFO_DEPTH) - count;
  assign space_ok = (free_cnt >= {{(FIFO_AW-2){1'b0}}, grp_words});
  assign wr_req   = wr_en && !reg_mode;
  assign wr_ack   = wr_req && space_ok;

  assign add_cnt    = wr_ack ? {{(FIFO_AW-2){1'b0}}, grp_words} : '0;
  assign sub_cnt    = {{FIFO_AW{1'b0}}, rd_en};
  assign fifo_empty = (count == '0);

  // Storage, no reset
  always_ff @(posedge m_ns_fwd_clk) begin
    if (wr_ack) begin
      for (int i = 0; i < 4; i++) begin
        if (i < grp_words) begin
          mem[wr_ptr + FIFO_AW'(i)] <= grp_word[i];
        end
      end
    end
  end

  always_ff @(posedge m_ns_fwd_clk or negedge rd_rstn) begin
    if (!rd_rstn) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      tx_fifo_ovf <= 1'b0;
    end else begin
      if (wr_ack) begin
        wr_ptr <= wr_ptr + grp_words[FIFO_AW-2:0];   // Group of 4 wraps on 16
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + add_cnt - sub_cnt;
      if (wr_req && !space_ok) begin
        tx_fifo_ovf <= 1'b1;   // Sticky until reset
      end
    end
  end

  // Read word lands one cycle after rd_en
  always_ff @(posedge m_ns_fwd_clk or negedge rd_rstn) begin
    if (!rd_rstn) begin
      fifo_dout <= '0;
    end else if (rd_en) begin
      fifo_dout <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

//--- hw/aib_tx_ctrl.sv
// TX channel control
// Mode decode, phase-comp start delay and read/valid pipeline
`timescale 1ns/1ps
`default_nettype none

module aib_tx_ctrl (
  input  logic       m_ns_fwd_clk,
  input  logic       rd_rstn,
  input  logic [1:0] r_tx_fifo_mode,
  input  logic [3:0] r_tx_phcomp_rd_delay,
  input  logic       wr_ack,
  input  logic       fifo_empty,
  output logic [2:0] grp_words,
  output logic       reg_mode,
  output logic       rd_en,
  output logic       fifo_vld,
  output logic       dout_vld
);

  import aib_tx_pkg::*;

  logic       armed;     // First write seen
  logic       started;
  logic [3:0] dly_cnt;

  // Words per write group
  always_comb begin
    case (r_tx_fifo_mode)
      MODE_FULL:    grp_words = 3'd1;
      MODE_HALF:    grp_words = 3'd2;
      MODE_QUARTER: grp_words = 3'd4;
      default:      grp_words = 3'd1;   // Register mode, FIFO idle
    endcase
  end

  assign reg_mode = (r_tx_fifo_mode == MODE_REG);

  // Start delay runs once, from the first accepted write after reset
  always_ff @(posedge m_ns_fwd_clk or negedge rd_rstn) begin
    if (!rd_rstn) begin
      armed   <= 1'b0;
      started <= 1'b0;
      dly_cnt <= 4'd0;
    end else begin
      if (!armed) begin
        if (wr_ack) begin
          armed   <= 1'b1;
          dly_cnt <= 4'd0;
        end
      end else if (!started) begin
        if (dly_cnt == r_tx_phcomp_rd_delay) begin
          started <= 1'b1;
        end else begin
          dly_cnt <= dly_cnt + 4'd1;
        end
      end
    end
  end

  // Drain one word per cycle once started
  assign rd_en = started && !fifo_empty && !reg_mode;

  // fifo_vld lines up with fifo_dout, dout_vld with the DBI register
  always_ff @(posedge m_ns_fwd_clk or negedge rd_rstn) begin
    if (!rd_rstn) begin
      fifo_vld <= 1'b0;
      dout_vld <= 1'b0;
    end else begin
      fifo_vld <= rd_en;
      dout_vld <= reg_mode ? 1'b1 : fifo_vld;   // Bypass word every cycle
    end
  end

endmodule

`default_nettype wire

//--- hw/aib_rstn_sync.sv
// Reset synchronizer with scan bypass
`timescale 1ns/1ps
`default_nettype none

module aib_rstn_sync (
  input  logic m_ns_fwd_clk,
  input  logic arst_n,
  input  logic atpg_mode,
  output logic rd_rstn
);

  logic sync_q1;
  logic sync_q2;

  // Assert async, release on the clock
  always_ff @(posedge m_ns_fwd_clk or negedge arst_n) begin
    if (!arst_n) begin
      sync_q1 <= 1'b0;
      sync_q2 <= 1'b0;
    end else begin
      sync_q1 <= 1'b1;
      sync_q2 <= sync_q1;
    end
  end

  // Scan drives the raw reset straight through
  assign rd_rstn = atpg_mode ? arst_n : sync_q2;

endmodule

`default_nettype wire

//--- hw/aib_tx_pkg.sv
// Die-to-die adapter TX channel
// Shared widths, mode codes and word layout
`default_nettype none

package aib_tx_pkg;

  // Word geometry
  localparam int WORD_W = 80;
  localparam int HALF_W = 40;
  localparam int IN_W   = 320;   // Four words per quarter-rate write

  // FIFO sizing
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // r_tx_fifo_mode encodings
  localparam logic [1:0] MODE_FULL    = 2'b00;
  localparam logic [1:0] MODE_HALF    = 2'b01;
  localparam logic [1:0] MODE_QUARTER = 2'b10;
  localparam logic [1:0] MODE_REG     = 2'b11;   // FIFO bypass

  // Marker lands at MK_BASE + r_tx_mkbit, never on bit 79
  localparam int MK_BASE = 40;

  // One half-word, flag on top
  typedef struct packed {
    logic              dbi;
    logic [HALF_W-2:0] data;
  } tx_half_t;

  typedef struct packed {
    tx_half_t hi;
    tx_half_t lo;
  } tx_pair_t;

  // Same 80 bits seen flat or as two halves
  typedef union packed {
    logic [WORD_W-1:0] flat;
    tx_pair_t          halves;
  } tx_word_u;

endpackage

`default_nettype wire
